// ==== hw/debayer_defines.svh ====
`ifndef DEBAYER_DEFINES_SVH
`define DEBAYER_DEFINES_SVH

// bits per raw pixel and per colour channel
`define PIX_W 16

// raw pixels carried by one input beat
`define PIX_PER_BEAT 4

// beats per line a line memory can hold
`define LINE_DEPTH 2048

// address width matching LINE_DEPTH
`define LINE_ADDR_W 11

// line memories in rotation
`define LINE_RAMS 3

`endif

// ==== hw/debayer_pkg.sv ====
`include "debayer_defines.svh"

package debayer_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;

	// pixel 0 is leftmost and sits in the top bits
	typedef pixel_t [0:`PIX_PER_BEAT-1] beat_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	typedef rgb_t [0:`PIX_PER_BEAT-1] rgb_beat_t;

	// three rows at one column position
	typedef struct packed {
		beat_t above;
		beat_t center;
		beat_t below;
	} row_taps_t;

	typedef enum logic {
		ROW_RG = 1'b0,
		ROW_GB = 1'b1
	} row_phase_e;

	// complete lines stored so far in this frame
	typedef enum logic [1:0] {
		FILL_EMPTY = 2'd0,
		FILL_ONE   = 2'd1,
		FILL_READY = 2'd2
	} fill_state_e;

	// bayer site, encoded as {row is GB, column is odd}
	typedef enum logic [1:0] {
		SITE_R  = 2'b00,
		SITE_GR = 2'b01,
		SITE_GB = 2'b10,
		SITE_B  = 2'b11
	} site_e;

	typedef struct packed {
		row_taps_t  prev;
		row_taps_t  cur;
		row_taps_t  next;
		row_phase_e phase;
	} window_t;

endpackage

// ==== hw/line_ram.sv ====
`include "debayer_defines.svh"

module line_ram (
	input  logic                    clk_i,
	input  logic                    we_i,
	input  logic [`LINE_ADDR_W-1:0] waddr_i,
	input  debayer_pkg::beat_t      wdata_i,
	input  logic [`LINE_ADDR_W-1:0] raddr_i,
	output debayer_pkg::beat_t      rdata_o
);

	debayer_pkg::beat_t mem [`LINE_DEPTH];

	always_ff @(posedge clk_i)
	begin
		if (we_i)
		begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i]; // registered read, one cycle
	end

endmodule

// ==== hw/line_buffer.sv ====
`include "debayer_defines.svh"

module line_buffer (
	input  logic                    clk_i,
	input  logic                    line_valid_i,
	input  logic                    line_active_i,
	input  logic                    data_valid_i,
	input  debayer_pkg::beat_t      data_i,
	output debayer_pkg::row_taps_t  taps_o,
	output debayer_pkg::row_phase_e taps_phase_o,
	output logic                    taps_valid_o,
	output logic                    line_end_o
);

	logic [`LINE_ADDR_W-1:0]  addr_q;
	logic [`LINE_RAMS-1:0]    wr_sel_q;
	logic [`LINE_RAMS-1:0]    ctr_sel;
	logic [`LINE_RAMS-1:0]    abv_sel;
	logic                     active_q;
	logic                     beat_acc;
	logic                     line_fall;
	debayer_pkg::fill_state_e fill_q;
	debayer_pkg::row_phase_e  phase_q;
	debayer_pkg::beat_t       below_q;
	debayer_pkg::beat_t       center_mux;
	debayer_pkg::beat_t       above_mux;
	debayer_pkg::beat_t       rd_data [`LINE_RAMS];

	assign beat_acc  = line_active_i & data_valid_i;
	assign line_fall = active_q & ~line_active_i; // first idle cycle after a line

	// previous line sits one RAM behind the write pointer, the one before that two behind
	assign ctr_sel = {wr_sel_q[0], wr_sel_q[`LINE_RAMS-1:1]};
	assign abv_sel = {wr_sel_q[`LINE_RAMS-2:0], wr_sel_q[`LINE_RAMS-1]};

	for (genvar i = 0; i < `LINE_RAMS; i++)
	begin : g_ram
		line_ram u_ram (
			.clk_i   (clk_i),
			.we_i    (beat_acc & wr_sel_q[i]),
			.waddr_i (addr_q),
			.wdata_i (data_i),
			.raddr_i (addr_q),
			.rdata_o (rd_data[i])
		);
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			addr_q       <= '0;
			active_q     <= 1'b0;
			line_end_o   <= 1'b0;
			taps_valid_o <= 1'b0;
			wr_sel_q     <= `LINE_RAMS'(1);
			fill_q       <= debayer_pkg::FILL_EMPTY;
			phase_q      <= debayer_pkg::ROW_RG;
		end
		else
		begin
			active_q     <= line_active_i;
			line_end_o   <= line_fall;
			taps_valid_o <= beat_acc && (fill_q != debayer_pkg::FILL_EMPTY);
			if (!line_active_i)
			begin
				addr_q <= '0;
			end
			else if (data_valid_i)
			begin
				addr_q <= addr_q + 1'b1;
			end
			if (line_fall)
			begin
				wr_sel_q <= abv_sel; // oldest RAM takes the next line
				if (fill_q != debayer_pkg::FILL_EMPTY)
				begin
					phase_q <= (phase_q == debayer_pkg::ROW_RG) ?
						debayer_pkg::ROW_GB : debayer_pkg::ROW_RG;
				end
				unique case (fill_q)
					debayer_pkg::FILL_EMPTY: fill_q <= debayer_pkg::FILL_ONE;
					debayer_pkg::FILL_ONE:   fill_q <= debayer_pkg::FILL_READY;
					default:                 fill_q <= debayer_pkg::FILL_READY;
				endcase
			end
		end
	end

	// newest row lines up with the RAM read data
	always_ff @(posedge clk_i)
	begin
		if (beat_acc)
		begin
			below_q <= data_i;
		end
	end

	always_comb
	begin
		center_mux = '0;
		above_mux  = '0;
		for (int i = 0; i < `LINE_RAMS; i++)
		begin
			if (ctr_sel[i])
			begin
				center_mux = rd_data[i];
			end
			if (abv_sel[i])
			begin
				above_mux = rd_data[i];
			end
		end
	end

	assign taps_o.above  = (fill_q == debayer_pkg::FILL_ONE) ? '0 : above_mux; // top row of frame
	assign taps_o.center = center_mux;
	assign taps_o.below  = below_q;
	assign taps_phase_o  = phase_q;

endmodule

// ==== hw/window_shift.sv ====
module window_shift (
	input  logic                    clk_i,
	input  logic                    line_valid_i,
	input  debayer_pkg::row_taps_t  taps_i,
	input  debayer_pkg::row_phase_e taps_phase_i,
	input  logic                    taps_valid_i,
	input  logic                    line_end_i,
	output debayer_pkg::window_t    win_o,
	output logic                    win_valid_o
);

	debayer_pkg::row_taps_t  cur_q;
	debayer_pkg::row_taps_t  prev_q;
	debayer_pkg::row_phase_e phase_q;
	logic                    pending_q;

	// control side, cur_q zero means the left edge pads with zeros
	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			cur_q       <= '0;
			phase_q     <= debayer_pkg::ROW_RG;
			pending_q   <= 1'b0;
			win_valid_o <= 1'b0;
		end
		else
		begin
			win_valid_o <= 1'b0;
			if (line_end_i)
			begin
				win_valid_o <= pending_q; // flush last beat
				pending_q   <= 1'b0;
				cur_q       <= '0;
			end
			else if (taps_valid_i)
			begin
				win_valid_o <= pending_q;
				pending_q   <= 1'b1;
				cur_q       <= taps_i;
				phase_q     <= taps_phase_i; // phase flips with line_end, keep our own
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (line_end_i)
		begin
			win_o.prev  <= prev_q;
			win_o.cur   <= cur_q;
			win_o.next  <= '0;
			win_o.phase <= phase_q;
		end
		else if (taps_valid_i)
		begin
			prev_q      <= cur_q;
			win_o.prev  <= prev_q;
			win_o.cur   <= cur_q;
			win_o.next  <= taps_i;
			win_o.phase <= phase_q;
		end
	end

endmodule

// ==== hw/demosaic_core.sv ====
`include "debayer_defines.svh"

module demosaic_core (
	input  logic                   clk_i,
	input  logic                   line_valid_i,
	input  debayer_pkg::window_t   win_i,
	input  logic                   win_valid_i,
	output debayer_pkg::rgb_beat_t pix_o,
	output logic                   pix_valid_o
);

	// one row of a beat plus one pixel of context on each side
	typedef debayer_pkg::pixel_t [0:`PIX_PER_BEAT+1] ext_row_t;

	ext_row_t               row_a;
	ext_row_t               row_m;
	ext_row_t               row_b;
	debayer_pkg::rgb_beat_t pix_d;

	function automatic ext_row_t ext_row(
		input debayer_pkg::beat_t p,
		input debayer_pkg::beat_t c,
		input debayer_pkg::beat_t n
	);
		return {p[`PIX_PER_BEAT-1], c, n[0]};
	endfunction

	assign row_a = ext_row(win_i.prev.above, win_i.cur.above, win_i.next.above);
	assign row_m = ext_row(win_i.prev.center, win_i.cur.center, win_i.next.center);
	assign row_b = ext_row(win_i.prev.below, win_i.cur.below, win_i.next.below);

	for (genvar j = 0; j < `PIX_PER_BEAT; j++)
	begin : g_pix
		localparam int col = j + 1;

		logic [`PIX_W+1:0]  orth_sum;
		logic [`PIX_W+1:0]  diag_sum;
		logic [`PIX_W:0]    horz_sum;
		logic [`PIX_W:0]    vert_sum;
		debayer_pkg::site_e site;
		debayer_pkg::rgb_t  rgb;

		// beats hold an even pixel count, so parity is the index parity
		assign site = debayer_pkg::site_e'({win_i.phase == debayer_pkg::ROW_GB, (j % 2) == 1});

		assign orth_sum = {2'b00, row_a[col]} + row_b[col] + row_m[col-1] + row_m[col+1];
		assign diag_sum = {2'b00, row_a[col-1]} + row_a[col+1] + row_b[col-1] + row_b[col+1];
		assign horz_sum = {1'b0, row_m[col-1]} + row_m[col+1];
		assign vert_sum = {1'b0, row_a[col]} + row_b[col];

		always_comb
		begin
			rgb = '0;
			unique case (site)
				debayer_pkg::SITE_R:
				begin
					rgb.r = row_m[col];
					rgb.g = orth_sum[`PIX_W+1:2];
					rgb.b = diag_sum[`PIX_W+1:2];
				end
				debayer_pkg::SITE_GR:
				begin
					rgb.r = horz_sum[`PIX_W:1]; // red left and right
					rgb.g = row_m[col];
					rgb.b = vert_sum[`PIX_W:1];
				end
				debayer_pkg::SITE_GB:
				begin
					rgb.r = vert_sum[`PIX_W:1]; // red above and below
					rgb.g = row_m[col];
					rgb.b = horz_sum[`PIX_W:1];
				end
				debayer_pkg::SITE_B:
				begin
					rgb.r = diag_sum[`PIX_W+1:2];
					rgb.g = orth_sum[`PIX_W+1:2];
					rgb.b = row_m[col];
				end
			endcase
		end

		assign pix_d[j] = rgb;
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			pix_valid_o <= 1'b0;
		end
		else
		begin
			pix_valid_o <= win_valid_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (win_valid_i)
		begin
			pix_o <= pix_d;
		end
	end

endmodule

// ==== hw/debayer_top.sv ====
module debayer_top (
	input  logic                   clk_i,
	input  logic                   line_valid_i,  // async reset, starts a frame
	input  logic                   line_active_i, // high for the length of a line
	input  logic                   data_valid_i,
	input  debayer_pkg::beat_t     data_i,
	output logic                   output_valid_o,
	output debayer_pkg::rgb_beat_t output_o
);

	debayer_pkg::row_taps_t  taps;
	debayer_pkg::row_phase_e taps_phase;
	logic                    taps_valid;
	logic                    line_end;
	debayer_pkg::window_t    win;
	logic                    win_valid;

	line_buffer u_line_buffer (
		.clk_i         (clk_i),
		.line_valid_i  (line_valid_i),
		.line_active_i (line_active_i),
		.data_valid_i  (data_valid_i),
		.data_i        (data_i),
		.taps_o        (taps),
		.taps_phase_o  (taps_phase),
		.taps_valid_o  (taps_valid),
		.line_end_o    (line_end)
	);

	window_shift u_window_shift (
		.clk_i        (clk_i),
		.line_valid_i (line_valid_i),
		.taps_i       (taps),
		.taps_phase_i (taps_phase),
		.taps_valid_i (taps_valid),
		.line_end_i   (line_end),
		.win_o        (win),
		.win_valid_o  (win_valid)
	);

	demosaic_core u_demosaic_core (
		.clk_i        (clk_i),
		.line_valid_i (line_valid_i),
		.win_i        (win),
		.win_valid_i  (win_valid),
		.pix_o        (output_o),
		.pix_valid_o  (output_valid_o)
	);

endmodule

// ==== verif/debayer_model.svh ====
`ifndef DEBAYER_MODEL_SVH
`define DEBAYER_MODEL_SVH

debayer_pkg::pixel_t frame_pix [0:7][0:8*`PIX_PER_BEAT-1]; // up to 8 lines of 8 beats
int                  frame_lines;
int                  frame_beats;
logic [31:0]         rng_state = 32'he16f_ee7a;

function automatic logic [31:0] next_rand();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// ramp or xorshift content
function automatic void load_frame(input int lines, input int beats, input bit use_rand);
	frame_lines = lines;
	frame_beats = beats;
	for (int l = 0; l < lines; l++)
	begin
		for (int x = 0; x < beats * `PIX_PER_BEAT; x++)
		begin
			frame_pix[l][x] = use_rand ? `PIX_W'(next_rand()) : `PIX_W'(l * 4096 + x * 291 + 64);
		end
	end
endfunction

// anything outside the frame reads as zero
function automatic int pix_at(input int l, input int x);
	if (l < 0 || l >= frame_lines || x < 0 || x >= frame_beats * `PIX_PER_BEAT)
		return 0;
	return int'(frame_pix[l][x]);
endfunction

// bilinear demosaic of one pixel of center row c
function automatic debayer_pkg::rgb_t model_rgb(input int c, input int x);
	int                nat;
	int                orth;
	int                diag;
	int                horz;
	int                vert;
	debayer_pkg::rgb_t px;
	nat  = pix_at(c, x);
	orth = (pix_at(c - 1, x) + pix_at(c + 1, x) + pix_at(c, x - 1) + pix_at(c, x + 1)) / 4;
	diag = (pix_at(c - 1, x - 1) + pix_at(c - 1, x + 1) +
		pix_at(c + 1, x - 1) + pix_at(c + 1, x + 1)) / 4;
	horz = (pix_at(c, x - 1) + pix_at(c, x + 1)) / 2;
	vert = (pix_at(c - 1, x) + pix_at(c + 1, x)) / 2;
	case ({c % 2 == 1, x % 2 == 1})
		2'b00:   px = {`PIX_W'(nat), `PIX_W'(orth), `PIX_W'(diag)}; // red site
		2'b01:   px = {`PIX_W'(horz), `PIX_W'(nat), `PIX_W'(vert)}; // green on an RG row
		2'b10:   px = {`PIX_W'(vert), `PIX_W'(nat), `PIX_W'(horz)}; // green on a GB row
		default: px = {`PIX_W'(diag), `PIX_W'(orth), `PIX_W'(nat)}; // blue site
	endcase
	return px;
endfunction

function automatic debayer_pkg::rgb_beat_t model_beat(input int c, input int b);
	debayer_pkg::rgb_beat_t beat;
	for (int j = 0; j < `PIX_PER_BEAT; j++)
	begin
		beat[j] = model_rgb(c, b * `PIX_PER_BEAT + j);
	end
	return beat;
endfunction

`endif

// ==== verif/debayer_tb.sv ====
`include "debayer_defines.svh"

module debayer_tb;

	localparam int CLK_PERIOD     = 100;
	localparam int DRIVE_DELAY    = 10;
	localparam int PIPE_CYCLES    = 3;    // line_buffer, window_shift, demosaic_core
	localparam int TIMEOUT_CYCLES = 3000; // the tests need a few hundred cycles

	logic                   clk;
	logic                   line_valid;
	logic                   line_active;
	logic                   data_valid;
	debayer_pkg::beat_t     data;
	logic                   output_valid;
	debayer_pkg::rgb_beat_t output_data;

	int                     cyc = 0;
	int                     test_errs = 0;
	int                     err_count = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;
	debayer_pkg::rgb_beat_t out_q [$];
	int                     out_cyc_q [$];
	int                     exp_cyc_q [$]; // cycle each output beat is due in

	`include "debayer_model.svh"

	debayer_top UUT (
		.clk_i          (clk),
		.line_valid_i   (line_valid),
		.line_active_i  (line_active),
		.data_valid_i   (data_valid),
		.data_i         (data),
		.output_valid_o (output_valid),
		.output_o       (output_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the tests did not finish", cyc);
			$display("Regression failed");
			$finish;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (output_valid === 1'b1)
		begin
			out_q.push_back(output_data);
			out_cyc_q.push_back(cyc);
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic reset_dut();
		line_valid  = 1'b1;
		line_active = 1'b0;
		data_valid  = 1'b0;
		data        = '0;
		repeat (3) step_cycle();
		line_valid = 1'b0;
		step_cycle();
		out_q.delete();
		out_cyc_q.delete();
		exp_cyc_q.delete();
	endtask

	// fewer beats than the frame width leaves the line open
	task automatic drive_line(input int l, input bit gaps, input int beats);
		int idle;
		line_active = 1'b1;
		for (int b = 0; b < beats; b++)
		begin
			idle       = gaps ? int'(next_rand() % 3) : 0;
			data_valid = 1'b0;
			repeat (idle) step_cycle();
			for (int j = 0; j < `PIX_PER_BEAT; j++)
				data[j] = frame_pix[l][b * `PIX_PER_BEAT + j];
			data_valid = 1'b1;
			if (l > 0 && b > 0)
				exp_cyc_q.push_back(cyc + PIPE_CYCLES); // releases the beat before
			step_cycle();
		end
		data_valid = 1'b0;
		if (beats < frame_beats)
			return;
		line_active = 1'b0;
		if (l > 0)
			exp_cyc_q.push_back(cyc + PIPE_CYCLES); // flush of the last beat
		repeat (2) step_cycle();
	endtask

	task automatic run_frame(input bit gaps);
		for (int l = 0; l < frame_lines; l++)
			drive_line(l, gaps, frame_beats);
		repeat (PIPE_CYCLES) step_cycle();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		err_count += test_errs;
		if (test_errs == 0)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic check_frame(input string name);
		int                     n_exp;
		debayer_pkg::rgb_beat_t exp;
		n_exp = (frame_lines - 1) * frame_beats; // last row has no line below
		if (out_q.size() != n_exp)
		begin
			$display("%s: DUT gave %0d output beats instead of %0d", name, out_q.size(), n_exp);
			test_errs++;
		end
		for (int i = 0; i < out_q.size() && i < n_exp; i++)
		begin
			exp = model_beat(i / frame_beats, i % frame_beats);
			if (out_q[i] !== exp)
			begin
				$display("ERROR %s: output_o beat %0d = %h, expected %h", name, i, out_q[i], exp);
				test_errs++;
			end
			if (i < exp_cyc_q.size() && out_cyc_q[i] != exp_cyc_q[i])
			begin
				$display("%s: output beat %0d came in cycle %0d instead of cycle %0d",
					name, i, out_cyc_q[i], exp_cyc_q[i]);
				test_errs++;
			end
		end
		finish_test(name);
	endtask

	task automatic first_line_silent();
		reset_dut();
		if (output_valid !== 1'b0)
		begin
			$display("ERROR first_line: output_valid_o = %h after reset, expected 0", output_valid);
			test_errs++;
		end
		load_frame(1, 4, 1'b0);
		run_frame(1'b0);
		check_frame("first_line");
	endtask

	task automatic ramp_frame();
		reset_dut();
		load_frame(3, 3, 1'b0);
		run_frame(1'b0);
		check_frame("ramp_3x3");
	endtask

	task automatic random_frame();
		reset_dut();
		load_frame(4, 5, 1'b1);
		run_frame(1'b0);
		check_frame("random_4x5");
	endtask

	// frame left in place by random_frame
	task automatic gapped_random_frame();
		reset_dut();
		run_frame(1'b1);
		check_frame("random_4x5_gaps");
	endtask

	task automatic gapped_latency();
		reset_dut();
		load_frame(4, 2, 1'b0);
		run_frame(1'b1);
		check_frame("latency_gaps");
	endtask

	task automatic mid_frame_reset();
		reset_dut();
		load_frame(3, 4, 1'b0);
		drive_line(0, 1'b0, 4);
		drive_line(1, 1'b0, 4);
		drive_line(2, 1'b0, 2);
		load_frame(3, 4, 1'b1);
		reset_dut(); // lands inside line 2
		run_frame(1'b0);
		check_frame("mid_frame_reset");
	endtask

	initial
	begin
		first_line_silent();
		ramp_frame();
		random_frame();
		gapped_random_frame();
		gapped_latency();
		mid_frame_reset();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (tests_failed == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hw
+incdir+verif
hw/debayer_pkg.sv
hw/line_ram.sv
hw/line_buffer.sv
hw/window_shift.sv
hw/demosaic_core.sv
hw/debayer_top.sv
verif/debayer_tb.sv

// ==== Bender.yml ====
package:
  name: debayer

sources:
  - include_dirs:
      - hw
    files:
      - hw/debayer_pkg.sv
      - hw/line_ram.sv
      - hw/line_buffer.sv
      - hw/window_shift.sv
      - hw/demosaic_core.sv
      - hw/debayer_top.sv
  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/debayer_tb.sv
